//--- Makefile
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f soc_bus.f --top-module soc_bus_top
	verilator --lint-only --timing --timescale 1ns/100ps -f soc_bus.f --top-module soc_bus_tb

sim:
	verilator --binary --timing --timescale 1ns/100ps -j 0 -f soc_bus.f \
		--top-module soc_bus_tb -Mdir obj_dir
	./obj_dir/Vsoc_bus_tb | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- soc_bus.f
+incdir+source
source/soc_bus_pkg.sv
source/ram_port.sv
source/plic_timer_regs.sv
source/bus_responder.sv
source/soc_bus_top.sv
verification/soc_bus_tb.sv

//--- source/bus_responder.sv
`default_nettype none

`include "soc_bus_config.svh"

module bus_responder (
    input  logic                   clock_slow,
    input  logic                   KEY0,
    input  soc_bus_pkg::bus_word_t bus_address,
    input  soc_bus_pkg::bus_word_t bus_write_data,
    input  soc_bus_pkg::ls_type_e  bus_ls_type,
    input  logic                   bus_read_enable,
    input  logic                   bus_write_enable,
    input  logic                   ram_ack,
    input  soc_bus_pkg::bus_word_t ram_rdata,
    input  logic                   regs_ack,
    input  soc_bus_pkg::bus_word_t regs_rdata,
    output soc_bus_pkg::bus_word_t bus_read_data,
    output logic                   bus_read_done,
    output logic                   bus_write_done,
    output logic                   step_go_ram,
    output logic                   step_go_regs,
    output logic                   step_write,
    output soc_bus_pkg::bus_word_t req_address,
    output soc_bus_pkg::ls_type_e  req_ls_type,
    output soc_bus_pkg::bus_word_t req_write_data
);
    import soc_bus_pkg::*;

    target_e   decoded;
    target_e   target;
    // request latched, go strobe due next edge
    logic      launch;
    logic      accept;
    logic      busy;
    bus_word_t captured;

    // an enable is taken only with both dones high and nothing launching
    assign accept = (bus_read_enable || bus_write_enable)
                 && bus_read_done && bus_write_done && !launch;
    assign busy   = !bus_read_done || !bus_write_done;

    always_comb begin
        if (bus_address >= `SOC_RAM_BASE
            && bus_address < `SOC_RAM_BASE + 64'(4 * `SOC_RAM_WORDS))
            decoded = TARGET_RAM;
        else if (bus_address == `SOC_MTIME || bus_address == `SOC_MTIMECMP
                 || (bus_address >= `SOC_PLIC_BASE
                     && bus_address < `SOC_PLIC_CLAIM + 64'h1004))
            decoded = TARGET_REGS;
        else
            decoded = TARGET_UNMAPPED;
    end

    // read data of the acking part, zero for an unmapped read
    always_comb begin
        case (target)
            TARGET_RAM:  captured = ram_rdata;
            TARGET_REGS: captured = regs_rdata;
            default:     captured = '0;
        endcase
    end

    always_ff @(posedge clock_slow or negedge KEY0) begin
        if (!KEY0) begin
            launch         <= 1'b0;
            target         <= TARGET_NONE;
            step_write     <= 1'b0;
            step_go_ram    <= 1'b0;
            step_go_regs   <= 1'b0;
            bus_read_done  <= 1'b1;
            bus_write_done <= 1'b1;
            bus_read_data  <= '0;
        end else begin
            step_go_ram  <= 1'b0;
            step_go_regs <= 1'b0;
            launch       <= accept;
            if (accept) begin
                target     <= decoded;
                // read wins when both enables arrive together
                step_write <= !bus_read_enable;
            end
            // done falls one edge after the enable is sampled
            if (launch) begin
                if (step_write)
                    bus_write_done <= 1'b0;
                else
                    bus_read_done <= 1'b0;
                step_go_ram  <= (target == TARGET_RAM);
                step_go_regs <= (target == TARGET_REGS);
            end
            // unmapped completes the edge after done fell
            if (ram_ack || regs_ack || (busy && target == TARGET_UNMAPPED)) begin
                if (step_write) begin
                    bus_write_done <= 1'b1;
                end else begin
                    bus_read_done <= 1'b1;
                    bus_read_data <= captured;
                end
            end
        end
    end

    // request payload held for the whole access
    always_ff @(posedge clock_slow) begin
        if (accept) begin
            req_address    <= bus_address;
            req_ls_type    <= bus_ls_type;
            req_write_data <= bus_write_data;
        end
    end

endmodule

`default_nettype wire

//--- source/plic_timer_regs.sv
`default_nettype none

`include "soc_bus_config.svh"

module plic_timer_regs (
    input  logic                   clock_slow,
    input  logic                   KEY0,
    input  logic                   step_go,
    input  logic                   step_write,
    input  soc_bus_pkg::bus_word_t req_address,
    input  soc_bus_pkg::bus_word_t req_write_data,
    input  soc_bus_pkg::bus_word_t mtime,
    input  logic                   ext_irq,
    output logic                   ack,
    output soc_bus_pkg::bus_word_t rdata,
    output soc_bus_pkg::bus_word_t mtimecmp,
    output logic                   meip_interrupt,
    output logic                   msip_interrupt
);
    import soc_bus_pkg::*;

    localparam int PRIO_BITS = $clog2(`SOC_PLIC_SOURCES);

    // interrupt controller state, two contexts
    logic [2:0]  prio [`SOC_PLIC_SOURCES];
    logic [31:0] pending;
    logic [31:0] enable [2];
    // stored only, never compared
    logic [2:0]  threshold [2];
    logic [31:0] claim_id [2];

    // external line sync and edge detect
    logic irq_q;
    logic irq_prev;
    logic irq_rise;

    // register decode
    bus_word_t            prio_offset;
    logic [PRIO_BITS-1:0] prio_index;
    logic                 sel_priority;
    logic                 sel_pending;
    logic [1:0]           sel_enable;
    logic [1:0]           sel_threshold;
    logic [1:0]           sel_claim;
    logic                 sel_mtime;
    logic                 sel_mtimecmp;
    bus_word_t            read_value;

    assign irq_rise = irq_q && !irq_prev;

    assign prio_offset  = req_address - `SOC_PLIC_BASE;
    assign prio_index   = prio_offset[2 +: PRIO_BITS];
    assign sel_priority = (req_address >= `SOC_PLIC_BASE)
                       && (req_address < `SOC_PLIC_BASE + 64'(4 * `SOC_PLIC_SOURCES));
    assign sel_pending  = (req_address == `SOC_PLIC_PENDING);
    // context 0 and 1 copies
    assign sel_enable    = {req_address == `SOC_PLIC_ENABLE + 64'h80,
                            req_address == `SOC_PLIC_ENABLE};
    assign sel_threshold = {req_address == `SOC_PLIC_THRESHOLD + 64'h1000,
                            req_address == `SOC_PLIC_THRESHOLD};
    assign sel_claim     = {req_address == `SOC_PLIC_CLAIM + 64'h1000,
                            req_address == `SOC_PLIC_CLAIM};
    assign sel_mtime     = (req_address == `SOC_MTIME);
    assign sel_mtimecmp  = (req_address == `SOC_MTIMECMP);

    // only one source, so the claim is that id or nothing
    always_comb begin
        for (int c = 0; c < 2; c++)
            claim_id[c] = (pending[`SOC_IRQ_ID] && enable[c][`SOC_IRQ_ID])
                        ? 32'(`SOC_IRQ_ID) : 32'd0;
    end

    assign meip_interrupt = (claim_id[0] != 32'd0);
    assign msip_interrupt = (claim_id[1] != 32'd0);

    // read mux, selects are one-hot
    always_comb begin
        read_value = '0;
        if (sel_priority)
            read_value = {61'd0, prio[prio_index]};
        if (sel_pending)
            read_value = {32'd0, pending};
        for (int c = 0; c < 2; c++) begin
            if (sel_enable[c])
                read_value = {32'd0, enable[c]};
            if (sel_threshold[c])
                read_value = {61'd0, threshold[c]};
            if (sel_claim[c])
                read_value = {32'd0, claim_id[c]};
        end
        if (sel_mtime)
            read_value = mtime;
        if (sel_mtimecmp)
            read_value = mtimecmp;
    end

    always_ff @(posedge clock_slow or negedge KEY0) begin
        if (!KEY0) begin
            irq_q    <= 1'b0;
            irq_prev <= 1'b0;
            ack      <= 1'b0;
            pending  <= '0;
            mtimecmp <= `SOC_MTIMECMP_RESET;
            for (int i = 0; i < `SOC_PLIC_SOURCES; i++)
                prio[i] <= '0;
            for (int c = 0; c < 2; c++) begin
                enable[c]    <= '0;
                threshold[c] <= '0;
            end
        end else begin
            irq_q    <= ext_irq;
            irq_prev <= irq_q;
            // every access is a single step
            ack <= step_go;
            if (irq_rise)
                pending[`SOC_IRQ_ID] <= 1'b1;
            // pending, mtime and claim writes fall through
            if (step_go && step_write) begin
                if (sel_priority)
                    prio[prio_index] <= req_write_data[2:0];
                if (sel_mtimecmp)
                    mtimecmp <= req_write_data;
                for (int c = 0; c < 2; c++) begin
                    if (sel_enable[c])
                        enable[c] <= req_write_data[31:0];
                    if (sel_threshold[c])
                        threshold[c] <= req_write_data[2:0];
                end
            end
            // claim read clears the claimed source, wins over a new edge
            if (step_go && !step_write) begin
                for (int c = 0; c < 2; c++) begin
                    if (sel_claim[c] && claim_id[c] != 32'd0)
                        pending[`SOC_IRQ_ID] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clock_slow) begin
        if (step_go && !step_write)
            rdata <= read_value;
    end

endmodule

`default_nettype wire

//--- source/ram_port.sv
`default_nettype none

`include "soc_bus_config.svh"

module ram_port (
    input  logic                   clock_slow,
    input  logic                   KEY0,
    input  logic                   step_go,
    input  logic                   step_write,
    input  soc_bus_pkg::bus_word_t req_address,
    input  soc_bus_pkg::ls_type_e  req_ls_type,
    input  soc_bus_pkg::bus_word_t req_write_data,
    output logic                   ack,
    output soc_bus_pkg::bus_word_t rdata
);
    import soc_bus_pkg::*;

    // word storage
    logic [31:0] mem [`SOC_RAM_WORDS];

    // high in the cycle of the upper word of ld/sd
    logic        second_step;
    logic        access;
    bus_word_t   ram_offset;
    ram_index_t  step_index;
    logic [1:0]  byte_offset;
    // per-lane write strobes and lane data
    logic [3:0]  lane_we;
    logic [31:0] lane_data;

    // shift word down to the addressed byte, then extend by type
    function automatic bus_word_t load_extend(
        input logic [31:0] word,
        input logic [1:0]  offset,
        input ls_type_e    ls_type
    );
        logic [31:0] shifted;
        shifted = word >> {offset, 3'b000};
        case (ls_type)
            LS_B:    return {{56{shifted[7]}}, shifted[7:0]};
            LS_H:    return {{48{shifted[15]}}, shifted[15:0]};
            LS_BU:   return {56'd0, shifted[7:0]};
            LS_HU:   return {48'd0, shifted[15:0]};
            LS_WU:   return {32'd0, shifted};
            // lw, sign extended
            default: return {{32{shifted[31]}}, shifted};
        endcase
    endfunction

    assign access      = step_go || second_step;
    assign byte_offset = req_address[1:0];

    // byte offset from ram base, then word index
    // second step moves to the next word
    assign ram_offset = req_address - `SOC_RAM_BASE;
    assign step_index = ram_offset[2 +: $bits(ram_index_t)] + ram_index_t'(second_step);

    always_comb begin
        case (req_ls_type)
            LS_B: begin
                // sb, data replicated on all lanes
                lane_we   = 4'b0001 << byte_offset;
                lane_data = {4{req_write_data[7:0]}};
            end
            LS_H: begin
                // sh at offset 0 or 2 only
                lane_we   = byte_offset[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{req_write_data[15:0]}};
            end
            LS_D: begin
                lane_we   = 4'b1111;
                lane_data = second_step ? req_write_data[63:32] : req_write_data[31:0];
            end
            default: begin
                lane_we   = 4'b1111;
                lane_data = req_write_data[31:0];
            end
        endcase
    end

    // step sequencing
    always_ff @(posedge clock_slow or negedge KEY0) begin
        if (!KEY0) begin
            second_step <= 1'b0;
            ack         <= 1'b0;
        end else begin
            second_step <= step_go && (req_ls_type == LS_D);
            // ack after the last word step
            ack <= (step_go && (req_ls_type != LS_D)) || second_step;
        end
    end

    // memory write and registered read
    always_ff @(posedge clock_slow) begin
        if (access && step_write) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (lane_we[lane])
                    mem[step_index][8*lane +: 8] <= lane_data[8*lane +: 8];
            end
        end
        if (access && !step_write) begin
            if (req_ls_type != LS_D)
                rdata <= load_extend(mem[step_index], byte_offset, req_ls_type);
            else if (second_step)
                rdata[63:32] <= mem[step_index];
            else
                rdata[31:0] <= mem[step_index];
        end
    end

endmodule

`default_nettype wire

//--- source/soc_bus_config.svh
`ifndef SOC_BUS_CONFIG_SVH
`define SOC_BUS_CONFIG_SVH

// on-chip ram, 2 KB of 32-bit words
`define SOC_RAM_WORDS 512
`define SOC_RAM_BASE 64'h0000_0000_8000_0000

// machine timer registers
`define SOC_MTIME 64'h0000_0000_0200_BFF8
`define SOC_MTIMECMP 64'h0000_0000_0200_4000
// compare value out of reset, far enough ahead of mtime
`define SOC_MTIMECMP_RESET 64'h0000_0000_8000_0000

// interrupt controller base and priority table
`define SOC_PLIC_BASE 64'h0000_0000_0C00_0000
`define SOC_PLIC_SOURCES 6

// pending bitmap
`define SOC_PLIC_PENDING (`SOC_PLIC_BASE + 64'h1000)
// enable bitmap, context 1 at +0x80
`define SOC_PLIC_ENABLE (`SOC_PLIC_BASE + 64'h2000)
// threshold, context 1 at +0x1000
`define SOC_PLIC_THRESHOLD (`SOC_PLIC_BASE + 64'h20_0000)
// claim, context 1 at +0x1000
`define SOC_PLIC_CLAIM (`SOC_PLIC_BASE + 64'h20_0004)

// source id of the external interrupt line
`define SOC_IRQ_ID 1

`endif

//--- source/soc_bus_pkg.sv
`default_nettype none

`include "soc_bus_config.svh"

package soc_bus_pkg;

    // one bus address or data word
    typedef logic [63:0] bus_word_t;

    // load/store type as driven by the cpu
    // stores use the signed codes 0 to 3
    typedef enum logic [2:0] {
        LS_B  = 3'd0,
        LS_H  = 3'd1,
        LS_W  = 3'd2,
        LS_D  = 3'd3,
        LS_BU = 3'd4,
        LS_HU = 3'd5,
        LS_WU = 3'd6
    } ls_type_e;

    // latched decode result of one request
    typedef enum logic [1:0] {
        TARGET_NONE,
        TARGET_RAM,
        TARGET_REGS,
        TARGET_UNMAPPED
    } target_e;

    // word index into the on-chip ram
    typedef logic [$clog2(`SOC_RAM_WORDS)-1:0] ram_index_t;

endpackage

`default_nettype wire

//--- source/soc_bus_top.sv
`default_nettype none

module soc_bus_top (
    input  logic                   clock_slow,
    input  logic                   KEY0,
    input  soc_bus_pkg::bus_word_t bus_address,
    input  soc_bus_pkg::bus_word_t bus_write_data,
    input  soc_bus_pkg::ls_type_e  bus_ls_type,
    input  logic                   bus_read_enable,
    input  logic                   bus_write_enable,
    input  soc_bus_pkg::bus_word_t mtime,
    input  logic                   ext_irq,
    output soc_bus_pkg::bus_word_t bus_read_data,
    output logic                   bus_read_done,
    output logic                   bus_write_done,
    output soc_bus_pkg::bus_word_t mtimecmp,
    output logic                   meip_interrupt,
    output logic                   msip_interrupt
);
    import soc_bus_pkg::*;

    // latched request, shared by both parts
    logic      step_go_ram;
    logic      step_go_regs;
    logic      step_write;
    bus_word_t req_address;
    ls_type_e  req_ls_type;
    bus_word_t req_write_data;
    // answers back to the responder
    logic      ram_ack;
    bus_word_t ram_rdata;
    logic      regs_ack;
    bus_word_t regs_rdata;

    bus_responder u_responder (
        .clock_slow       (clock_slow),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_ls_type      (bus_ls_type),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .ram_ack          (ram_ack),
        .ram_rdata        (ram_rdata),
        .regs_ack         (regs_ack),
        .regs_rdata       (regs_rdata),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done),
        .step_go_ram      (step_go_ram),
        .step_go_regs     (step_go_regs),
        .step_write       (step_write),
        .req_address      (req_address),
        .req_ls_type      (req_ls_type),
        .req_write_data   (req_write_data)
    );

    ram_port u_ram (
        .clock_slow     (clock_slow),
        .KEY0           (KEY0),
        .step_go        (step_go_ram),
        .step_write     (step_write),
        .req_address    (req_address),
        .req_ls_type    (req_ls_type),
        .req_write_data (req_write_data),
        .ack            (ram_ack),
        .rdata          (ram_rdata)
    );

    plic_timer_regs u_regs (
        .clock_slow     (clock_slow),
        .KEY0           (KEY0),
        .step_go        (step_go_regs),
        .step_write     (step_write),
        .req_address    (req_address),
        .req_write_data (req_write_data),
        .mtime          (mtime),
        .ext_irq        (ext_irq),
        .ack            (regs_ack),
        .rdata          (regs_rdata),
        .mtimecmp       (mtimecmp),
        .meip_interrupt (meip_interrupt),
        .msip_interrupt (msip_interrupt)
    );

endmodule

`default_nettype wire

//--- verification/soc_bus_tb.sv
`default_nettype none

`include "soc_bus_config.svh"

module soc_bus_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import soc_bus_pkg::*;

    // about twice what ~300 accesses of at most 6 cycles plus reset need
    localparam int CYCLE_LIMIT  = 4000;
    // cycles one access may take before it counts as stuck
    localparam int ACCESS_LIMIT = 20;

    logic      clock_slow;
    logic      KEY0;
    bus_word_t bus_address;
    bus_word_t bus_write_data;
    ls_type_e  bus_ls_type;
    logic      bus_read_enable;
    logic      bus_write_enable;
    bus_word_t mtime;
    logic      ext_irq;
    bus_word_t bus_read_data;
    logic      bus_read_done;
    logic      bus_write_done;
    bus_word_t mtimecmp;
    logic      meip_interrupt;
    logic      msip_interrupt;

    // reference state
    logic [31:0] ram_model [`SOC_RAM_WORDS];
    logic [2:0]  prio_model [`SOC_PLIC_SOURCES];
    bus_word_t   mtimecmp_model;
    // data of the last completed read
    bus_word_t   last_read_data;
    int          sd_index[$];
    int          written_index[$];

    int     value_errors = 0;
    int     other_errors = 0;
    int     cycle_count = 0;
    integer seed;

    soc_bus_top UUT (
        .clock_slow       (clock_slow),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_ls_type      (bus_ls_type),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .mtime            (mtime),
        .ext_irq          (ext_irq),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done),
        .mtimecmp         (mtimecmp),
        .meip_interrupt   (meip_interrupt),
        .msip_interrupt   (msip_interrupt)
    );

    always #5 clock_slow = ~clock_slow;

    // run limit
    always @(posedge clock_slow) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic bus_word_t random_word();
        return {$random(seed), $random(seed)};
    endfunction

    // uniform pick in 0 .. limit-1
    function automatic int random_index(input int limit);
        return int'($unsigned($random(seed)) % 32'(limit));
    endfunction

    function automatic bus_word_t ram_address(input int idx, input int lane);
        return `SOC_RAM_BASE + bus_word_t'(4 * idx + lane);
    endfunction

    function automatic int word_index(input bus_word_t addr);
        bus_word_t offset;
        offset = addr - `SOC_RAM_BASE;
        return int'(offset[10:2]);
    endfunction

    // sb one lane, sh two lanes, sw one word, sd two words
    task automatic model_store(input bus_word_t addr, input ls_type_e t, input bus_word_t data);
        int idx;
        int lane;
        idx  = word_index(addr);
        lane = int'(addr[1:0]);
        case (t)
            LS_B: ram_model[idx][8*lane +: 8] = data[7:0];
            LS_H: ram_model[idx][8*lane +: 16] = data[15:0];
            LS_D: begin
                ram_model[idx]     = data[31:0];
                ram_model[idx + 1] = data[63:32];
            end
            default: ram_model[idx] = data[31:0];
        endcase
    endtask

    // signed load types extend the top bit
    function automatic bus_word_t model_load(input bus_word_t addr, input ls_type_e t);
        int          idx;
        int          lane;
        logic [31:0] w;
        logic [15:0] h;
        logic [7:0]  b;
        idx  = word_index(addr);
        lane = int'(addr[1:0]);
        w    = ram_model[idx];
        b    = w[8*lane +: 8];
        h    = (lane >= 2) ? w[31:16] : w[15:0];
        case (t)
            LS_B:    return bus_word_t'($signed(b));
            LS_H:    return bus_word_t'($signed(h));
            LS_W:    return bus_word_t'($signed(w));
            LS_D:    return {ram_model[idx + 1], w};
            LS_BU:   return {56'd0, b};
            LS_HU:   return {48'd0, h};
            default: return {32'd0, w};
        endcase
    endfunction

    task automatic check_value(input string name, input bus_word_t expected,
                               input bus_word_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("mismatch at %0t: %s expected %h actual %h",
                     $time, name, expected, actual);
        end
    endtask

    // done must fall and then rise
    // cycles counted from the sampling edge
    task automatic wait_done(input logic is_read, input int expected, input bus_word_t addr);
        int   cycles;
        logic seen_low;
        logic finished;
        cycles   = 0;
        seen_low = 1'b0;
        finished = 1'b0;
        while (!finished && cycles < ACCESS_LIMIT) begin
            @(posedge clock_slow);
            cycles++;
            @(negedge clock_slow);
            if (is_read ? !bus_read_done : !bus_write_done)
                seen_low = 1'b1;
            else if (seen_low)
                finished = 1'b1;
        end
        if (!finished) begin
            other_errors++;
            $display("access to %h never completed, at %0t", addr, $time);
        end else if (cycles != expected) begin
            other_errors++;
            $display("access to %h took %0d cycles instead of %0d, at %0t",
                     addr, cycles, expected, $time);
        end
    endtask

    task automatic bus_read(input bus_word_t addr, input ls_type_e t, input int cycles,
                            output bus_word_t data);
        @(posedge clock_slow);
        bus_address     <= addr;
        bus_ls_type     <= t;
        bus_read_enable <= 1'b1;
        @(posedge clock_slow);
        bus_read_enable <= 1'b0;
        wait_done(1'b1, cycles, addr);
        data = bus_read_data;
    endtask

    task automatic bus_write(input bus_word_t addr, input ls_type_e t, input bus_word_t data,
                             input int cycles);
        @(posedge clock_slow);
        bus_address      <= addr;
        bus_ls_type      <= t;
        bus_write_data   <= data;
        bus_write_enable <= 1'b1;
        @(posedge clock_slow);
        bus_write_enable <= 1'b0;
        wait_done(1'b0, cycles, addr);
        // a write leaves the last read data alone
        check_value("bus_read_data", last_read_data, bus_read_data);
    endtask

    task automatic read_expect(input bus_word_t addr, input ls_type_e t, input int cycles,
                               input bus_word_t expected);
        bus_word_t data;
        bus_read(addr, t, cycles, data);
        check_value("bus_read_data", expected, data);
        last_read_data = expected;
    endtask

    task automatic ram_write(input int idx, input int lane, input ls_type_e t,
                             input bus_word_t data);
        bus_write(ram_address(idx, lane), t, data, (t == LS_D) ? 4 : 3);
        model_store(ram_address(idx, lane), t, data);
    endtask

    task automatic ram_read_check(input int idx, input int lane, input ls_type_e t);
        read_expect(ram_address(idx, lane), t, (t == LS_D) ? 4 : 3,
                    model_load(ram_address(idx, lane), t));
    endtask

    task automatic check_reset_state();
        check_value("bus_read_done", 64'd1, bus_word_t'(bus_read_done));
        check_value("bus_write_done", 64'd1, bus_word_t'(bus_write_done));
        check_value("bus_read_data", 64'd0, bus_read_data);
        check_value("meip_interrupt", 64'd0, bus_word_t'(meip_interrupt));
        check_value("msip_interrupt", 64'd0, bus_word_t'(msip_interrupt));
        check_value("mtimecmp", `SOC_MTIMECMP_RESET, mtimecmp);
    endtask

    task automatic test_ram_words();
        int idx;
        repeat (24) begin
            // double stores on even words so both halves stay in range
            idx = 2 * random_index(`SOC_RAM_WORDS / 2);
            ram_write(idx, 0, LS_D, random_word());
            sd_index.push_back(idx);
            written_index.push_back(idx);
            written_index.push_back(idx + 1);
        end
        repeat (24) begin
            idx = random_index(`SOC_RAM_WORDS);
            ram_write(idx, 0, LS_W, random_word());
            written_index.push_back(idx);
        end
        // loads only from words with known contents
        repeat (60) begin
            case (random_index(3))
                0: ram_read_check(written_index[random_index(written_index.size())], 0, LS_W);
                1: ram_read_check(written_index[random_index(written_index.size())], 0, LS_WU);
                default: ram_read_check(sd_index[random_index(sd_index.size())], 0, LS_D);
            endcase
        end
    endtask

    task automatic test_narrow();
        int idx;
        repeat (4) begin
            idx = random_index(`SOC_RAM_WORDS);
            ram_write(idx, 0, LS_W, random_word());
            // each narrow store merged into the word and seen by lw
            for (int lane = 0; lane < 4; lane++) begin
                ram_write(idx, lane, LS_B, random_word());
                ram_read_check(idx, 0, LS_W);
            end
            for (int lane = 0; lane < 4; lane += 2) begin
                ram_write(idx, lane, LS_H, random_word());
                ram_read_check(idx, 0, LS_W);
            end
            for (int lane = 0; lane < 4; lane++) begin
                ram_read_check(idx, lane, LS_B);
                ram_read_check(idx, lane, LS_BU);
            end
            for (int lane = 0; lane < 4; lane += 2) begin
                ram_read_check(idx, lane, LS_H);
                ram_read_check(idx, lane, LS_HU);
            end
        end
    endtask

    // one interrupt round through context ctx
    task automatic irq_claim_round(input int ctx);
        bus_word_t claim;
        claim = `SOC_PLIC_CLAIM + bus_word_t'(ctx) * 64'h1000;
        bus_write(`SOC_PLIC_ENABLE + bus_word_t'(ctx) * 64'h80, LS_W, 64'h2, 3);
        bus_write(`SOC_PLIC_ENABLE + bus_word_t'(1 - ctx) * 64'h80, LS_W, 64'h0, 3);
        check_value("meip_interrupt", 64'd0, bus_word_t'(meip_interrupt));
        check_value("msip_interrupt", 64'd0, bus_word_t'(msip_interrupt));
        @(posedge clock_slow);
        ext_irq <= 1'b1;
        @(negedge clock_slow);
        // input register, then edge detect
        @(negedge clock_slow);
        check_value("meip_interrupt", 64'd0, bus_word_t'(meip_interrupt));
        check_value("msip_interrupt", 64'd0, bus_word_t'(msip_interrupt));
        @(negedge clock_slow);
        check_value("meip_interrupt", bus_word_t'(ctx == 0), bus_word_t'(meip_interrupt));
        check_value("msip_interrupt", bus_word_t'(ctx == 1), bus_word_t'(msip_interrupt));
        read_expect(`SOC_PLIC_PENDING, LS_W, 3, 64'h2);
        read_expect(claim, LS_W, 3, 64'(`SOC_IRQ_ID));
        check_value("meip_interrupt", 64'd0, bus_word_t'(meip_interrupt));
        check_value("msip_interrupt", 64'd0, bus_word_t'(msip_interrupt));
        // nothing left to claim
        read_expect(claim, LS_W, 3, 64'd0);
        @(posedge clock_slow);
        ext_irq <= 1'b0;
    endtask

    task automatic test_plic();
        bus_word_t data;
        for (int i = 0; i < `SOC_PLIC_SOURCES; i++) begin
            data = random_word();
            bus_write(`SOC_PLIC_BASE + bus_word_t'(4 * i), LS_W, data, 3);
            prio_model[i] = data[2:0];
        end
        for (int i = 0; i < `SOC_PLIC_SOURCES; i++)
            read_expect(`SOC_PLIC_BASE + bus_word_t'(4 * i), LS_W, 3, {61'd0, prio_model[i]});
        for (int c = 0; c < 2; c++) begin
            data = random_word();
            bus_write(`SOC_PLIC_ENABLE + bus_word_t'(c) * 64'h80, LS_W, data, 3);
            read_expect(`SOC_PLIC_ENABLE + bus_word_t'(c) * 64'h80, LS_W, 3,
                        {32'd0, data[31:0]});
            data = random_word();
            bus_write(`SOC_PLIC_THRESHOLD + bus_word_t'(c) * 64'h1000, LS_W, data, 3);
            read_expect(`SOC_PLIC_THRESHOLD + bus_word_t'(c) * 64'h1000, LS_W, 3,
                        {61'd0, data[2:0]});
        end
        read_expect(`SOC_PLIC_PENDING, LS_W, 3, 64'd0);
        irq_claim_round(0);
        irq_claim_round(1);
    endtask

    task automatic test_timer();
        bus_word_t data;
        data = random_word();
        bus_write(`SOC_MTIMECMP, LS_D, data, 3);
        mtimecmp_model = data;
        check_value("mtimecmp", mtimecmp_model, mtimecmp);
        read_expect(`SOC_MTIMECMP, LS_D, 3, mtimecmp_model);
        data = random_word();
        @(posedge clock_slow);
        mtime <= data;
        read_expect(`SOC_MTIME, LS_D, 3, data);
    endtask

    task automatic test_unmapped();
        ram_write(0, 0, LS_W, random_word());
        ram_write(`SOC_RAM_WORDS - 1, 0, LS_W, random_word());
        // leave nonzero read data so the zero is visible
        ram_read_check(0, 0, LS_W);
        read_expect(64'h0000_0000_1000_0000, LS_W, 2, 64'd0);
        // just past ram, just below ram, past the claim registers
        bus_write(`SOC_RAM_BASE + 64'h800, LS_W, random_word(), 2);
        bus_write(`SOC_RAM_BASE - 64'h4, LS_W, random_word(), 2);
        bus_write(`SOC_PLIC_BASE + 64'h40_0000, LS_W, random_word(), 2);
        ram_read_check(0, 0, LS_W);
        ram_read_check(`SOC_RAM_WORDS - 1, 0, LS_W);
        for (int i = 0; i < `SOC_PLIC_SOURCES; i++)
            read_expect(`SOC_PLIC_BASE + bus_word_t'(4 * i), LS_W, 3, {61'd0, prio_model[i]});
        check_value("mtimecmp", mtimecmp_model, mtimecmp);
        read_expect(`SOC_MTIMECMP, LS_D, 3, mtimecmp_model);
    endtask

    initial begin
        seed             = 32'hf8b2_82f2;
        mtimecmp_model   = `SOC_MTIMECMP_RESET;
        last_read_data   = '0;
        clock_slow       = 1'b0;
        KEY0             = 1'b0;
        bus_address      = '0;
        bus_write_data   = '0;
        bus_ls_type      = LS_W;
        bus_read_enable  = 1'b0;
        bus_write_enable = 1'b0;
        mtime            = '0;
        ext_irq          = 1'b0;
        repeat (10) @(posedge clock_slow);
        KEY0 <= 1'b1;
        @(negedge clock_slow);
        check_reset_state();
        test_ram_words();
        test_narrow();
        test_plic();
        test_timer();
        test_unmapped();
        $display("errors: %0d mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire
